// ==== cpu_pkg.sv ====
package cpu_pkg;

    // ========================================================================
    // widths with a meaning
    // ========================================================================
    // signed register and memory word
    typedef logic signed [15:0] data_t;
    typedef logic [3:0]         reg_idx_t;
    // word address inside the 4 KB window
    typedef logic [10:0]        word_addr_t;
    typedef logic [6:0]         line_idx_t;
    // upper bits of word_addr_t
    typedef logic [3:0]         tag_t;
    typedef logic [31:0]        axi_addr_t;
    // branch and memory offset
    typedef logic signed [4:0]  imm_t;

    // ========================================================================
    // encodings and state machines
    // ========================================================================
    typedef enum logic [2:0] {
        op_arith   = 3'b000,
        op_cmp_mul = 3'b001,
        op_store   = 3'b010,
        op_load    = 3'b011,
        op_jump    = 3'b100,
        op_beq     = 3'b101
    } opcode_t;

    typedef enum logic [2:0] {
        core_idle, core_fetch, core_decode, core_execute,
        core_write_back, core_load, core_store
    } core_state_t;

    typedef enum logic [2:0] {
        cache_idle, cache_hit, cache_buffer, cache_send,
        cache_fill, cache_update, cache_out
    } cache_state_t;

    typedef enum logic [1:0] {
        writer_idle, writer_address, writer_data, writer_response
    } writer_state_t;

    // memory window, byte address
    localparam axi_addr_t MEM_BASE    = 32'h0000_1000;
    // words per cache line, one burst
    localparam int        BURST_BEATS = 128;

endpackage

// ==== reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     rd_en,
    input  logic     wr_en,
    input  data_t    wr_data,
    output data_t    rs_data,
    output data_t    rt_data
);

    // sixteen architectural registers
    data_t regs [16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            rs_data <= '0;
            rt_data <= '0;
        end else begin
            // single write port
            if (wr_en) begin
                regs[wr_idx] <= wr_data;
            end
            // operands held until the next decode
            if (rd_en) begin
                rs_data <= regs[rs_idx];
                rt_data <= regs[rt_idx];
            end
        end
    end

endmodule

// ==== line_cache.sv ====
module line_cache import cpu_pkg::*; #(
    parameter bit WRITABLE = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    // core request side
    input  logic       req_valid,
    input  word_addr_t req_addr,
    output logic       rsp_valid,
    output data_t      rsp_data,
    // store update side
    input  logic       st_valid,
    input  word_addr_t st_addr,
    input  data_t      st_data,
    // AXI read
    output axi_addr_t  araddr,
    output logic       arvalid,
    input  logic       arready,
    input  data_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    cache_state_t state, next_state;

    // line storage
    data_t      mem [BURST_BEATS];
    logic       valid_q;
    tag_t       tag_q;
    line_idx_t  beat_cnt;

    // latched request
    word_addr_t addr_q;
    data_t      st_q;
    data_t      rd_q;

    logic       line_hit;
    logic       st_hit;
    line_idx_t  addr_idx;

    assign addr_idx = addr_q[6:0];
    assign line_hit = valid_q && (tag_q == req_addr[10:7]);
    assign st_hit   = valid_q && (tag_q == st_addr[10:7]);

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            cache_idle: begin
                // a store also pulses req_valid, store takes priority
                if (WRITABLE && st_valid) begin
                    if (st_hit) begin
                        next_state = cache_update;
                    end
                end else if (req_valid) begin
                    next_state = line_hit ? cache_hit : cache_send;
                end
            end
            cache_hit:    next_state = cache_buffer;
            cache_buffer: next_state = cache_out;
            cache_send:   if (arready) next_state = cache_fill;
            cache_fill:   if (rvalid && rlast) next_state = cache_out;
            cache_update: next_state = cache_idle;
            cache_out:    next_state = cache_idle;
            default:      next_state = cache_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_idle;
            valid_q   <= 1'b0;
            tag_q     <= '0;
            beat_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            state     <= next_state;
            rsp_valid <= (next_state == cache_out);
            // line invalid while refilling
            if (state == cache_idle && next_state == cache_send) begin
                tag_q   <= req_addr[10:7];
                valid_q <= 1'b0;
            end else if (state == cache_fill && rvalid && rlast) begin
                valid_q <= 1'b1;
            end
            if (state == cache_send) begin
                beat_cnt <= '0;
            end else if (state == cache_fill && rvalid) begin
                beat_cnt <= beat_cnt + 7'd1;
            end
        end
    end

    // ========================================================================
    // array and response data
    // ========================================================================
    always_ff @(posedge clk) begin
        if (state == cache_idle) begin
            if (WRITABLE && st_valid) begin
                addr_q <= st_addr;
                st_q   <= st_data;
            end else if (req_valid) begin
                addr_q <= req_addr;
            end
        end
        if (state == cache_fill && rvalid) begin
            mem[beat_cnt] <= rdata;
        end else if (state == cache_update) begin
            mem[addr_idx] <= st_q;
        end
        // synchronous read, one cycle
        if (state == cache_hit) begin
            rd_q <= mem[addr_idx];
        end
        // forward the wanted beat straight from the bus
        if (state == cache_fill && rvalid && beat_cnt == addr_idx) begin
            rsp_data <= rdata;
        end else if (state == cache_buffer) begin
            rsp_data <= rd_q;
        end
    end

    // line aligned burst, 256 bytes per tag
    assign araddr  = MEM_BASE + {20'd0, tag_q, 8'd0};
    assign arvalid = (state == cache_send);
    assign rready  = (state == cache_fill);

endmodule

// ==== store_writer.sv ====
module store_writer import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // core side
    input  logic       st_valid,
    input  word_addr_t st_addr,
    input  data_t      st_data,
    output logic       st_done,
    // AXI write
    output axi_addr_t  awaddr,
    output logic       awvalid,
    input  logic       awready,
    output data_t      wdata,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready
);

    writer_state_t state, next_state;
    word_addr_t    addr_q;
    data_t         data_q;

    // ========================================================================
    // address, data, response in order
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            writer_idle:     if (st_valid) next_state = writer_address;
            writer_address:  if (awready) next_state = writer_data;
            writer_data:     if (wready) next_state = writer_response;
            writer_response: if (bvalid) next_state = writer_idle;
            default:         next_state = writer_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= writer_idle;
            st_done <= 1'b0;
        end else begin
            state   <= next_state;
            st_done <= (state == writer_response) && bvalid;
        end
    end

    // store held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == writer_idle && st_valid) begin
            addr_q <= st_addr;
            data_q <= st_data;
        end
    end

    assign awaddr  = MEM_BASE + {20'd0, addr_q, 1'b0};
    assign awvalid = (state == writer_address);
    // single beat, so every beat is the last
    assign wvalid  = (state == writer_data);
    assign wlast   = (state == writer_data);
    assign wdata   = data_q;
    assign bready  = (state == writer_response);

endmodule

// ==== cpu_core.sv ====
module cpu_core import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       io_stall,
    // instruction cache
    output logic       inst_req_valid,
    output word_addr_t pc_addr,
    input  logic       inst_valid,
    input  data_t      inst,
    // data cache and store writer
    output logic       data_req_valid,
    output word_addr_t data_addr,
    input  logic       data_valid,
    input  data_t      load_data,
    output logic       st_valid,
    output data_t      st_data,
    input  logic       st_done
);

    core_state_t state, next_state;

    // decoded fields
    data_t       inst_q;
    opcode_t     opcode;
    reg_idx_t    rs, rt, rd;
    logic        func;
    imm_t        imm;
    logic [12:0] target;

    logic [15:0] pc, pc_next, br_off;
    data_t       rs_data, rt_data, alu_res, alu_q, mem_sum;
    logic        enter_fetch, rd_en, wr_en;
    reg_idx_t    wr_idx;
    data_t       wr_data;

    assign opcode = opcode_t'(inst_q[15:13]);
    assign rs     = inst_q[12:9];
    assign rt     = inst_q[8:5];
    assign rd     = inst_q[4:1];
    assign func   = inst_q[0];
    assign imm    = inst_q[4:0];
    assign target = inst_q[12:0];

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            core_idle:   next_state = core_fetch;
            core_fetch:  if (inst_valid) next_state = core_decode;
            core_decode: next_state = core_execute;
            core_execute: begin
                case (opcode)
                    op_arith, op_cmp_mul: next_state = core_write_back;
                    op_load:              next_state = core_load;
                    op_store:             next_state = core_store;
                    // jump, branch, unused codes
                    default:              next_state = core_fetch;
                endcase
            end
            core_write_back: next_state = core_fetch;
            core_load:       if (data_valid) next_state = core_fetch;
            core_store:      if (st_done) next_state = core_fetch;
            default:         next_state = core_idle;
        endcase
    end

    // one retirement per return to fetch
    assign enter_fetch = (next_state == core_fetch) && (state != core_fetch);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= core_idle;
            pc             <= MEM_BASE[15:0];
            io_stall       <= 1'b1;
            inst_req_valid <= 1'b0;
            data_req_valid <= 1'b0;
            st_valid       <= 1'b0;
        end else begin
            state          <= next_state;
            io_stall       <= !(enter_fetch && state != core_idle);
            inst_req_valid <= enter_fetch;
            // stores pulse both paths together
            data_req_valid <= (state == core_execute) &&
                              (opcode == op_load || opcode == op_store);
            st_valid       <= (state == core_execute) && (opcode == op_store);
            if (state == core_execute) begin
                pc <= pc_next;
            end
        end
    end

    // ========================================================================
    // datapath
    // ========================================================================
    always_ff @(posedge clk) begin
        if (state == core_fetch && inst_valid) begin
            inst_q <= inst;
        end
        if (state == core_execute) begin
            alu_q     <= alu_res;
            data_addr <= mem_sum[10:0];
        end
    end

    always_comb begin
        alu_res = '0;
        if (opcode == op_arith) begin
            alu_res = func ? rs_data + rt_data : rs_data - rt_data;
        end else if (opcode == op_cmp_mul) begin
            // signed compare, product keeps low half
            if (func) begin
                alu_res = (rs_data < rt_data) ? 16'sd1 : 16'sd0;
            end else begin
                alu_res = rs_data * rt_data;
            end
        end
    end

    // offset in words, pc in bytes
    assign br_off  = {{10{imm[4]}}, imm, 1'b0};
    assign mem_sum = rs_data + {{11{imm[4]}}, imm};

    always_comb begin
        case (opcode)
            op_jump: pc_next = MEM_BASE[15:0] + {3'b000, target};
            op_beq:  pc_next = (rs_data == rt_data) ? pc + 16'd2 + br_off : pc + 16'd2;
            default: pc_next = pc + 16'd2;
        endcase
    end

    assign pc_addr = pc[11:1];
    assign st_data = rt_data;

    // loads write rt, alu ops write rd
    assign rd_en   = (state == core_decode);
    assign wr_en   = (state == core_write_back) || (state == core_load && data_valid);
    assign wr_idx  = (state == core_load) ? rt : rd;
    assign wr_data = (state == core_load) ? load_data : alu_q;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs),
        .rt_idx  (rt),
        .wr_idx  (wr_idx),
        .rd_en   (rd_en),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

// ==== cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output logic      io_stall,
    // instruction read port
    output axi_addr_t inst_araddr,
    output logic      inst_arvalid,
    input  logic      inst_arready,
    input  data_t     inst_rdata,
    input  logic      inst_rlast,
    input  logic      inst_rvalid,
    output logic      inst_rready,
    // data read port
    output axi_addr_t data_araddr,
    output logic      data_arvalid,
    input  logic      data_arready,
    input  data_t     data_rdata,
    input  logic      data_rlast,
    input  logic      data_rvalid,
    output logic      data_rready,
    // write port
    output axi_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    output data_t     wdata,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid,
    output logic      bready
);

    logic       inst_req_valid, inst_valid;
    word_addr_t pc_addr;
    data_t      inst;
    logic       data_req_valid, data_valid;
    word_addr_t data_addr;
    data_t      load_data;
    logic       st_valid, st_done;
    data_t      st_data;

    cpu_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .io_stall       (io_stall),
        .inst_req_valid (inst_req_valid),
        .pc_addr        (pc_addr),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .data_req_valid (data_req_valid),
        .data_addr      (data_addr),
        .data_valid     (data_valid),
        .load_data      (load_data),
        .st_valid       (st_valid),
        .st_data        (st_data),
        .st_done        (st_done)
    );

    // ========================================================================
    // caches, read only for instructions
    // ========================================================================
    line_cache #(.WRITABLE(1'b0)) u_inst_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (inst_req_valid),
        .req_addr  (pc_addr),
        .rsp_valid (inst_valid),
        .rsp_data  (inst),
        .st_valid  (1'b0),
        .st_addr   ('0),
        .st_data   ('0),
        .araddr    (inst_araddr),
        .arvalid   (inst_arvalid),
        .arready   (inst_arready),
        .rdata     (inst_rdata),
        .rlast     (inst_rlast),
        .rvalid    (inst_rvalid),
        .rready    (inst_rready)
    );

    line_cache #(.WRITABLE(1'b1)) u_data_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (data_req_valid),
        .req_addr  (data_addr),
        .rsp_valid (data_valid),
        .rsp_data  (load_data),
        .st_valid  (st_valid),
        .st_addr   (data_addr),
        .st_data   (st_data),
        .araddr    (data_araddr),
        .arvalid   (data_arvalid),
        .arready   (data_arready),
        .rdata     (data_rdata),
        .rlast     (data_rlast),
        .rvalid    (data_rvalid),
        .rready    (data_rready)
    );

    // write through for every store
    store_writer u_store_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .st_addr  (data_addr),
        .st_data  (st_data),
        .st_done  (st_done),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

endmodule

// ==== cpu_properties.sv ====
module cpu_properties import cpu_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      io_stall,
    input axi_addr_t inst_araddr,
    input logic      inst_arvalid,
    input logic      inst_arready,
    input axi_addr_t data_araddr,
    input logic      data_arvalid,
    input logic      data_arready,
    input logic      wvalid,
    input logic      wlast
);

    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures so far
    int error_cnt = 0;

    // ========================================================================
    // AXI read requests held until accepted
    // ========================================================================
    inst_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_arvalid && !inst_arready |=> inst_arvalid && $stable(inst_araddr))
    else begin
        error_cnt++;
        $error("instruction read request dropped or changed before arready");
    end

    data_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_arvalid && !data_arready |=> data_arvalid && $stable(data_araddr))
    else begin
        error_cnt++;
        $error("data read request dropped or changed before arready");
    end

    // single beat writes, so every data beat is the last
    w_single_beat: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wlast)
    else begin
        error_cnt++;
        $error("write data beat without wlast");
    end

    // one retirement, then at least a new fetch
    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !io_stall |=> io_stall)
    else begin
        error_cnt++;
        $error("io_stall low for two cycles in a row");
    end

endmodule

bind cpu_top cpu_properties u_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .io_stall     (io_stall),
    .inst_araddr  (inst_araddr),
    .inst_arvalid (inst_arvalid),
    .inst_arready (inst_arready),
    .data_araddr  (data_araddr),
    .data_arvalid (data_arvalid),
    .data_arready (data_arready),
    .wvalid       (wvalid),
    .wlast        (wlast)
);

// ==== tb_cpu.sv ====
module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED        = 32'h266f_069b;
    localparam int          N_RANDOM    = 220;
    // last of the sixteen closing stores
    localparam int          LAST_IDX    = N_RANDOM + 15;
    localparam int          MAX_DELAY   = 3;
    // arready wait plus 128 beats, each with its own wait
    localparam int          FILL_CYCLES = (MAX_DELAY + 1) * (BURST_BEATS + 1) + 8;
    // two fills per instruction, worst case
    localparam longint      TIMEOUT_NS  = longint'(N_RANDOM + 17) * 2 * FILL_CYCLES * 10;

    logic      clk, rst_n, io_stall;
    axi_addr_t inst_araddr, data_araddr, awaddr;
    logic      inst_arvalid, inst_arready, inst_rlast, inst_rvalid, inst_rready;
    logic      data_arvalid, data_arready, data_rlast, data_rvalid, data_rready;
    data_t     inst_rdata, data_rdata, wdata;
    logic      awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    // memory models, word indexed inside the window
    data_t     inst_mem [2048];
    data_t     data_mem [2048];

    // expected AXI writes in program order
    axi_addr_t exp_addr [$];
    data_t     exp_data [$];
    int        exp_retire;
    int        write_cnt  = 0;
    int        retire_cnt = 0;
    logic      run_done   = 1'b0;

    // one generator state per process
    logic [31:0] gen_rng  = SEED;
    logic [31:0] inst_rng = SEED + 32'd1;
    logic [31:0] data_rng = SEED + 32'd2;
    logic [31:0] wr_rng   = SEED + 32'd3;

    cpu_top DUT (.*);

    always #5 clk = ~clk;

    // ========================================================================
    // helpers
    // ========================================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    // ========================================================================
    // program generator
    // ========================================================================
    task automatic build_program();
        logic [31:0] r;
        reg_idx_t    rs, rt, rd;
        imm_t        imm;
        int          hop;
        int          i;
        for (int w = 0; w < 2048; w++) begin
            inst_mem[w] = '0;
            // odd multiplier, every address bit counts
            data_mem[w] = data_t'(32'(w) * 32'd40503 + 32'd4660);
        end
        i = 0;
        while (i < N_RANDOM) begin
            gen_rng = lcg_next(gen_rng);
            r       = gen_rng;
            rs      = r[28:25];
            rt      = r[24:21];
            rd      = r[20:17];
            imm     = r[15:11];
            hop     = r[14:11];
            case (r[31:29])
                3'd0, 3'd1: inst_mem[i] = {op_arith, rs, rt, rd, r[16]};
                3'd2, 3'd3: inst_mem[i] = {op_cmp_mul, rs, rt, rd, r[16]};
                3'd4:       inst_mem[i] = {op_load, rs, rt, imm};
                3'd5: begin
                    inst_mem[i] = {op_store, rs, rt, imm};
                    // read the stored word straight back half the time
                    if (r[16] && i + 1 < N_RANDOM) begin
                        i++;
                        inst_mem[i] = {op_load, rs, rt + 4'd1, imm};
                    end
                end
                3'd6: begin
                    // forward only, never past the closing stores
                    if (hop > N_RANDOM - 1 - i) begin
                        hop = N_RANDOM - 1 - i;
                    end
                    inst_mem[i] = {op_beq, rs, r[16] ? rs : rt, imm_t'(hop)};
                end
                default: begin
                    hop = i + 1 + hop;
                    if (hop > N_RANDOM) begin
                        hop = N_RANDOM;
                    end
                    inst_mem[i] = {op_jump, 13'(2 * hop)};
                end
            endcase
            i++;
        end
        // dump every register, then spin on a jump to self
        for (int k = 0; k < 16; k++) begin
            inst_mem[N_RANDOM + k] = {op_store, 4'd0, 4'(k), 5'(k)};
        end
        inst_mem[N_RANDOM + 16] = {op_jump, 13'(2 * (N_RANDOM + 16))};
    endtask

    // ========================================================================
    // reference instruction-set model
    // ========================================================================
    function automatic int run_reference();
        data_t       regs [16];
        data_t       dmem [2048];
        logic [15:0] pc, next_pc;
        data_t       word, a, b;
        reg_idx_t    rs, rt, rd;
        imm_t        imm;
        word_addr_t  idx, addr;
        int          off, retired;
        bit          done;
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 2048; w++) begin
            dmem[w] = data_mem[w];
        end
        exp_addr.delete();
        exp_data.delete();
        pc      = MEM_BASE[15:0];
        retired = 0;
        done    = 1'b0;
        while (!done && retired < 4 * N_RANDOM) begin
            // byte pc, two bytes per instruction
            idx     = word_addr_t'((pc - MEM_BASE[15:0]) >> 1);
            word    = inst_mem[idx];
            rs      = word[12:9];
            rt      = word[8:5];
            rd      = word[4:1];
            imm     = word[4:0];
            off     = imm;
            a       = regs[rs];
            b       = regs[rt];
            next_pc = pc + 16'd2;
            case (opcode_t'(word[15:13]))
                op_arith:   regs[rd] = word[0] ? a + b : a - b;
                op_cmp_mul: regs[rd] = word[0] ? ((a < b) ? data_t'(1) : data_t'(0))
                                               : data_t'(a * b);
                op_store: begin
                    addr       = word_addr_t'(a + off);
                    dmem[addr] = b;
                    exp_addr.push_back(MEM_BASE + 2 * axi_addr_t'(addr));
                    exp_data.push_back(b);
                end
                op_load:  regs[rt] = dmem[word_addr_t'(a + off)];
                op_jump:  next_pc = MEM_BASE[15:0] + 16'(word[12:0]);
                op_beq: begin
                    if (a == b) begin
                        next_pc = pc + 16'(2 + 2 * off);
                    end
                end
                default: ;
            endcase
            retired++;
            done = (idx == word_addr_t'(LAST_IDX));
            pc   = next_pc;
        end
        return retired;
    endfunction

    // ========================================================================
    // AXI memory models
    // ========================================================================
    // instruction read port, random waits before arready and each beat
    always begin
        word_addr_t base;
        @(negedge clk);
        if (inst_arvalid) begin
            inst_rng = lcg_next(inst_rng);
            repeat (inst_rng[31:30]) @(negedge clk);
            inst_arready = 1'b1;
            base         = word_addr_t'((inst_araddr - MEM_BASE) >> 1);
            @(negedge clk);
            inst_arready = 1'b0;
            for (int i = 0; i < BURST_BEATS; i++) begin
                inst_rng = lcg_next(inst_rng);
                repeat (inst_rng[31:30]) @(negedge clk);
                inst_rvalid = 1'b1;
                inst_rlast  = (i == BURST_BEATS - 1);
                inst_rdata  = inst_mem[base + word_addr_t'(i)];
                // cache must take every beat of the fill
                check_bit("inst_rready", inst_rready, 1'b1);
                @(negedge clk);
                inst_rvalid = 1'b0;
                inst_rlast  = 1'b0;
            end
        end
    end

    // data read port
    always begin
        word_addr_t base;
        @(negedge clk);
        if (data_arvalid) begin
            data_rng = lcg_next(data_rng);
            repeat (data_rng[31:30]) @(negedge clk);
            data_arready = 1'b1;
            base         = word_addr_t'((data_araddr - MEM_BASE) >> 1);
            @(negedge clk);
            data_arready = 1'b0;
            for (int i = 0; i < BURST_BEATS; i++) begin
                data_rng = lcg_next(data_rng);
                repeat (data_rng[31:30]) @(negedge clk);
                data_rvalid = 1'b1;
                data_rlast  = (i == BURST_BEATS - 1);
                data_rdata  = data_mem[base + word_addr_t'(i)];
                check_bit("data_rready", data_rready, 1'b1);
                @(negedge clk);
                data_rvalid = 1'b0;
                data_rlast  = 1'b0;
            end
        end
    end

    // write port, compares each write against the reference order
    always begin
        axi_addr_t got_addr;
        data_t     got_data;
        @(negedge clk);
        if (awvalid) begin
            wr_rng = lcg_next(wr_rng);
            repeat (wr_rng[31:30]) @(negedge clk);
            awready  = 1'b1;
            got_addr = awaddr;
            @(negedge clk);
            awready  = 1'b0;
            while (!wvalid) @(negedge clk);
            repeat (wr_rng[29:28]) @(negedge clk);
            wready   = 1'b1;
            got_data = wdata;
            @(negedge clk);
            wready   = 1'b0;
            if (write_cnt >= exp_addr.size()) begin
                $display("DUT made more AXI writes than the %0d expected", exp_addr.size());
                fail_run();
            end
            check_addr("awaddr", got_addr, exp_addr[write_cnt]);
            check_data("wdata", got_data, exp_data[write_cnt]);
            data_mem[word_addr_t'((got_addr - MEM_BASE) >> 1)] = got_data;
            repeat (wr_rng[27:26]) @(negedge clk);
            bvalid = 1'b1;
            // response phase waits with bready up
            check_bit("bready", bready, 1'b1);
            @(negedge clk);
            bvalid = 1'b0;
            write_cnt++;
        end
    end

    // ========================================================================
    // retirement count and end of program
    // ========================================================================
    always @(negedge clk) begin
        if (rst_n && !io_stall) begin
            retire_cnt++;
            // first retirement after the last write is the last store
            if (write_cnt == exp_addr.size()) begin
                run_done = 1'b1;
            end
        end
        if (DUT.u_properties.error_cnt != 0) begin
            $display("a bound assertion on cpu_top failed");
            fail_run();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with %0d of %0d writes seen",
                 TIMEOUT_NS, write_cnt, exp_addr.size());
        fail_run();
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_arready = 1'b0;
        inst_rdata   = '0;
        inst_rlast   = 1'b0;
        inst_rvalid  = 1'b0;
        data_arready = 1'b0;
        data_rdata   = '0;
        data_rlast   = 1'b0;
        data_rvalid  = 1'b0;
        awready      = 1'b0;
        wready       = 1'b0;
        bvalid       = 1'b0;
        build_program();
        exp_retire = run_reference();
        $display("reference: %0d retirements, %0d AXI writes", exp_retire, exp_addr.size());
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // bus stays quiet until the first instruction fetch
        while (!inst_arvalid) begin
            check_bit("io_stall", io_stall, 1'b1);
            check_bit("data_arvalid", data_arvalid, 1'b0);
            check_bit("awvalid", awvalid, 1'b0);
            check_bit("wvalid", wvalid, 1'b0);
            @(negedge clk);
        end
        wait (run_done);
        if (retire_cnt == exp_retire) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            check_count("io_stall low pulses", retire_cnt, exp_retire);
        end
    end

endmodule

// ==== src.f ====
cpu_pkg.sv
reg_file.sv
line_cache.sv
store_writer.sv
cpu_core.sv
cpu_top.sv
cpu_properties.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - cpu_pkg.sv
  - reg_file.sv
  - line_cache.sv
  - store_writer.sv
  - cpu_core.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_properties.sv
      - tb_cpu.sv
